// File: Bender.yml
package:
  name: intensity_correlator

sources:
  # RTL in compile order, package first
  - files:
      - src/corr_pkg.sv
      - src/sample_delay_bank.sv
      - src/baseline_correlator.sv
      - src/corr_axil_regs.sv
      - src/intensity_correlator.sv

  # bus monitor and testbench, top module corr_tb
  - target: simulation
    files:
      - sim/corr_sva.sv
      - sim/corr_tb.sv

// File: intensity_correlator.f
src/corr_pkg.sv
src/sample_delay_bank.sv
src/baseline_correlator.sv
src/corr_axil_regs.sv
src/intensity_correlator.sv
sim/corr_sva.sv
sim/corr_tb.sv

// File: sim/corr_sva.sv
// AXI4-Lite response monitor bound into every corr_axil_regs instance
// failures counts the failed assertions and is watched by the testbench
`timescale 1ns/1ns

module corr_sva (
	input logic                pllclk,
	input logic                reset,      // synchronous, active low
	input corr_pkg::axil_req_t s_axil_req,
	input corr_pkg::axil_rsp_t s_axil_rsp
);

	int unsigned failures = 0;

	// a write response stays up until the master takes it
	a_bvalid_hold: assert property (@(posedge pllclk) disable iff (!reset)
		s_axil_rsp.bvalid && !s_axil_req.bready |=> s_axil_rsp.bvalid)
		else begin $error("bvalid dropped before bready"); failures++; end

	// read data is held steady while rvalid waits for rready
	a_rvalid_hold: assert property (@(posedge pllclk) disable iff (!reset)
		s_axil_rsp.rvalid && !s_axil_req.rready |=>
		s_axil_rsp.rvalid && $stable(s_axil_rsp.rdata))
		else begin $error("rvalid or rdata changed before rready"); failures++; end

	// no response is pending in the cycle after reset
	a_reset_idle: assert property (@(posedge pllclk)
		!reset |=> !s_axil_rsp.bvalid && !s_axil_rsp.rvalid)
		else begin $error("bvalid or rvalid high after reset"); failures++; end

endmodule

bind corr_axil_regs corr_sva u_sva (
	.pllclk    (pllclk),
	.reset     (reset),
	.s_axil_req(s_axil_req),
	.s_axil_rsp(s_axil_rsp)
);

// File: sim/corr_tb.sv
// drives intensity_correlator with RESOLUTION lowered to 12 so that saturation is reachable
// registers are only read back while enable is low and the last products have landed
// AW and W arrive together or in either order and bready and rready come late at random
`timescale 1ns/1ns

module corr_tb;

	localparam int NUM_INPUTS    = 4;
	localparam int LAG_CROSS     = 3;
	localparam int SAMPLE_WIDTH  = 4;
	localparam int RESOLUTION    = 12;
	localparam int CHANNELS      = 2*LAG_CROSS - 1;
	localparam int TAPS          = LAG_CROSS + 1;
	localparam int NUM_BASELINES = NUM_INPUTS*(NUM_INPUTS-1)/2;
	localparam int NUM_ACC       = NUM_BASELINES*CHANNELS;
	localparam int DATA_W        = NUM_INPUTS*SAMPLE_WIDTH;
	localparam int AW            = corr_pkg::AXIL_ADDR_WIDTH;
	localparam int DW            = corr_pkg::AXIL_DATA_WIDTH;
	localparam int ACC_MAX       = (1 << (RESOLUTION-1)) - 1; // +2047
	localparam int ACC_MIN       = -(1 << (RESOLUTION-1));    // -2048
	localparam logic [SAMPLE_WIDTH-1:0] SAMPLE_MIN = 1 << (SAMPLE_WIDTH-1); // most negative sample
	localparam int MAX_GAP       = 3;                         // idle cycles between strobes
	localparam int RESET_CYC     = 8;
	localparam int STIM_CYC      = (200 + 30 + 40 + 50 + 200) * (MAX_GAP + 1) + 40;
	localparam int NUM_XFER      = 7 * (3 + 2*NUM_ACC) + 12;  // reads of every check plus writes
	localparam int XFER_CYC      = MAX_GAP + 6;               // worst single bus transaction
	localparam int TIMEOUT_CYC   = 2 * (RESET_CYC + STIM_CYC + NUM_XFER*XFER_CYC);

	logic                pllclk;
	logic                reset;
	logic [DATA_W-1:0]   adc_data;
	logic                sample_strobe;
	corr_pkg::axil_req_t axil_req;
	corr_pkg::axil_rsp_t axil_rsp;

	integer seed = 27588;
	int     cycle_count = 0;
	int     hist [NUM_INPUTS][TAPS]; // sample history per input with tap 0 the newest
	int     model_re [NUM_ACC];
	int     model_im [NUM_ACC];
	bit     model_ovf [NUM_ACC];
	int     model_count;
	bit     model_en;                // enable as last written over the bus

	intensity_correlator #(
		.NUM_INPUTS  (NUM_INPUTS),
		.LAG_CROSS   (LAG_CROSS),
		.SAMPLE_WIDTH(SAMPLE_WIDTH),
		.RESOLUTION  (RESOLUTION)
	) UUT (
		.pllclk       (pllclk),
		.reset        (reset),
		.adc_data     (adc_data),
		.sample_strobe(sample_strobe),
		.s_axil_req   (axil_req),
		.s_axil_rsp   (axil_rsp)
	);

	initial begin
		pllclk = 1'b0;
		forever #4 pllclk = ~pllclk; // 8 ns period
	end

	// hard limit on run length sized from the stimulus and bus traffic
	always @(posedge pllclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > TIMEOUT_CYC) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end else if (UUT.u_regs.u_sva.failures != 0) begin
			$display("bus monitor assertion failed on the AXI4-Lite port");
			$display("TEST RESULT: FAIL");
			$fatal(1, "assertion failure");
		end
	end

	task automatic check_value(input string name, input logic [DW-1:0] actual,
			input logic [DW-1:0] expected);
		if (actual !== expected) begin
			$display("ERR %s got 0x%08h expected 0x%08h", name, actual, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// clamps a sum to the signed accumulator range and sets hit when it was out of range
	function automatic int clamp_acc(input int sum, output bit hit);
		hit = (sum > ACC_MAX) || (sum < ACC_MIN);
		if (sum > ACC_MAX) return ACC_MAX;
		if (sum < ACC_MIN) return ACC_MIN;
		return sum;
	endfunction

	// one strobe in the model shifts the history and grows the sums only while enabled
	task automatic model_strobe(input logic [DATA_W-1:0] data);
		int bl;
		int d;
		int pa;
		int pb;
		int n;
		bit hit_re;
		bit hit_im;
		for (int i = 0; i < NUM_INPUTS; i++) begin
			for (int t = TAPS-1; t > 0; t--) hist[i][t] = hist[i][t-1];
			hist[i][0] = $signed(data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
		end
		if (!model_en) return;
		model_count++;
		bl = 0;
		for (int a = 0; a < NUM_INPUTS; a++) begin
			for (int b = a + 1; b < NUM_INPUTS; b++) begin
				for (int k = 0; k < CHANNELS; k++) begin
					d  = k - (LAG_CROSS-1);
					pa = (d < 0) ? -d : 0;        // negative offset delays input a
					pb = (d > 0) ? d : 0;
					n  = bl*CHANNELS + k;
					if (!model_ovf[n]) begin
						model_re[n]  = clamp_acc(model_re[n] + hist[a][pa]*hist[b][pb], hit_re);
						model_im[n]  = clamp_acc(model_im[n] + hist[a][pa]*hist[b][pb+1], hit_im);
						model_ovf[n] = hit_re | hit_im; // the channel freezes from here on
					end
				end
				bl++;
			end
		end
	endtask

	task automatic axil_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
		bit aw_done;
		bit w_done;
		int skew;
		int delay;
		aw_done = 1'b0;
		w_done  = 1'b0;
		skew    = {$random(seed)} % 3; // 0 together, 1 address first, 2 data first
		delay   = {$random(seed)} % (MAX_GAP + 1);
		@(posedge pllclk);
		axil_req.awaddr  <= addr;
		axil_req.awvalid <= (skew != 2);
		axil_req.wdata   <= data;
		axil_req.wstrb   <= '1;
		axil_req.wvalid  <= (skew != 1);
		while (!(aw_done && w_done)) begin
			@(posedge pllclk);
			if (!aw_done && axil_req.awvalid && axil_rsp.awready) begin
				aw_done = 1'b1;
				axil_req.awvalid <= 1'b0;
			end
			if (!w_done && axil_req.wvalid && axil_rsp.wready) begin
				w_done = 1'b1;
				axil_req.wvalid <= 1'b0;
			end
			if (aw_done && !w_done) axil_req.wvalid <= 1'b1;  // data follows the address
			if (w_done && !aw_done) axil_req.awvalid <= 1'b1; // address follows the data
		end
		do @(posedge pllclk); while (!axil_rsp.bvalid);
		check_value("bresp", DW'(axil_rsp.bresp), DW'(corr_pkg::RESP_OKAY));
		repeat (delay) @(posedge pllclk); // bready comes late so bvalid has to wait
		axil_req.bready <= 1'b1;
		@(posedge pllclk);
		axil_req.bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [AW-1:0] addr, output logic [DW-1:0] data);
		int delay;
		delay = {$random(seed)} % (MAX_GAP + 1);
		@(posedge pllclk);
		axil_req.araddr  <= addr;
		axil_req.arvalid <= 1'b1;
		do @(posedge pllclk); while (!axil_rsp.arready);
		axil_req.arvalid <= 1'b0;
		do @(posedge pllclk); while (!axil_rsp.rvalid);
		data = axil_rsp.rdata;
		check_value("rresp", DW'(axil_rsp.rresp), DW'(corr_pkg::RESP_OKAY));
		repeat (delay) @(posedge pllclk); // rdata must hold until rready
		axil_req.rready <= 1'b1;
		@(posedge pllclk);
		axil_req.rready <= 1'b0;
	endtask

	// writes REG_CTRL and mirrors it in the model where a clear zeros the sums, flags and count
	task automatic write_ctrl(input bit enable, input bit clear);
		axil_write(corr_pkg::REG_CTRL, {30'b0, clear, enable});
		model_en = enable;
		if (clear) begin
			model_count = 0;
			for (int n = 0; n < NUM_ACC; n++) begin
				model_re[n]  = 0;
				model_im[n]  = 0;
				model_ovf[n] = 1'b0;
			end
		end
	endtask

	// random or all most negative samples with 0 to MAX_GAP idle cycles after each strobe
	task automatic send_samples(input int count, input bit most_negative);
		logic [DATA_W-1:0] data;
		int gap;
		for (int s = 0; s < count; s++) begin
			data = most_negative ? {NUM_INPUTS{SAMPLE_MIN}} : DATA_W'($random(seed));
			gap  = {$random(seed)} % (MAX_GAP + 1);
			@(posedge pllclk);
			adc_data      <= data;
			sample_strobe <= 1'b1;
			model_strobe(data);
			repeat (gap) begin
				@(posedge pllclk);
				sample_strobe <= 1'b0;
			end
		end
		@(posedge pllclk);
		sample_strobe <= 1'b0;
		repeat (2) @(posedge pllclk); // last products reach the accumulators
	endtask

	// reads every register and accumulator and compares with the model
	task automatic check_all();
		logic [DW-1:0] rd;
		logic [NUM_BASELINES-1:0] ovf_exp;
		ovf_exp = '0;
		for (int m = 0; m < NUM_BASELINES; m++) begin
			for (int k = 0; k < CHANNELS; k++) ovf_exp[m] |= model_ovf[m*CHANNELS + k];
		end
		axil_read(corr_pkg::REG_CTRL, rd);
		check_value("REG_CTRL", rd, DW'(model_en));
		axil_read(corr_pkg::REG_COUNT, rd);
		check_value("REG_COUNT", rd, DW'(model_count));
		axil_read(corr_pkg::REG_OVF, rd);
		check_value("REG_OVF", rd, DW'(ovf_exp));
		for (int n = 0; n < NUM_ACC; n++) begin
			axil_read(corr_pkg::ACC_BASE + AW'(8*n), rd);
			check_value($sformatf("acc_real[%0d]", n), rd, model_re[n]);
			axil_read(corr_pkg::ACC_BASE + AW'(8*n + 4), rd);
			check_value($sformatf("acc_imag[%0d]", n), rd, model_im[n]);
		end
	endtask

	initial begin
		logic [DW-1:0] rd;
		reset         = 1'b0;
		adc_data      = '0;
		sample_strobe = 1'b0;
		axil_req      = '0;
		model_en      = 1'b0;
		model_count   = 0;
		foreach (hist[i, t]) hist[i][t] = 0;
		for (int n = 0; n < NUM_ACC; n++) begin
			model_re[n]  = 0;
			model_im[n]  = 0;
			model_ovf[n] = 1'b0;
		end
		repeat (RESET_CYC) @(posedge pllclk);
		reset <= 1'b1;
		check_all(); // everything reads zero after reset
		write_ctrl(1'b1, 1'b0);
		send_samples(200, 1'b0);
		write_ctrl(1'b0, 1'b0);
		repeat (2) @(posedge pllclk);
		check_all();
		send_samples(30, 1'b0); // only the history moves while enable is low
		check_all();
		write_ctrl(1'b1, 1'b1); // start the saturation run from zero
		send_samples(40, 1'b1);
		write_ctrl(1'b0, 1'b0);
		repeat (2) @(posedge pllclk);
		check_all();
		axil_read(corr_pkg::REG_OVF, rd);
		check_value("REG_OVF", rd, DW'((1 << NUM_BASELINES) - 1)); // every baseline flagged
		write_ctrl(1'b1, 1'b0);
		send_samples(50, 1'b0); // saturated channels stay frozen
		write_ctrl(1'b0, 1'b0);
		repeat (2) @(posedge pllclk);
		check_all();
		write_ctrl(1'b0, 1'b1);
		repeat (2) @(posedge pllclk);
		check_all();
		write_ctrl(1'b1, 1'b0);
		send_samples(200, 1'b0);
		write_ctrl(1'b0, 1'b0);
		repeat (2) @(posedge pllclk);
		check_all();
		if (UUT.u_regs.u_sva.failures == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("bus monitor reported %0d assertion failures", UUT.u_regs.u_sva.failures);
			$display("TEST RESULT: FAIL");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// File: src/baseline_correlator.sv
// real and quadrature lag accumulators for the input pair (INPUT_A, INPUT_B)
// accumulators are signed RESOLUTION bits and saturate, RESOLUTION must exceed 2*SAMPLE_WIDTH
// a channel whose real or imaginary sum hits a limit freezes until clear or reset
`timescale 1ns/1ns

module baseline_correlator #(
	parameter int INPUT_A      = 0,
	parameter int INPUT_B      = 1,
	parameter int NUM_INPUTS   = 4,
	parameter int LAG_CROSS    = 3,
	parameter int SAMPLE_WIDTH = 4,
	parameter int RESOLUTION   = 24
) (
	input  logic                                             pllclk,
	input  logic                                             reset,      // synchronous, active low
	input  logic [NUM_INPUTS*(LAG_CROSS+1)*SAMPLE_WIDTH-1:0] taps,
	input  logic                                             taps_valid,
	input  corr_pkg::corr_ctrl_t                             ctrl,
	output logic [(2*LAG_CROSS-1)*RESOLUTION-1:0]            acc_real,
	output logic [(2*LAG_CROSS-1)*RESOLUTION-1:0]            acc_imag,
	output logic [2*LAG_CROSS-2:0]                           ovf
);

	localparam int CHANNELS = 2*LAG_CROSS - 1;
	localparam int TAPS     = LAG_CROSS + 1;
	localparam int PROD_W   = 2*SAMPLE_WIDTH; // full width of one signed product
	localparam logic [RESOLUTION-1:0] ACC_MAX = {1'b0, {(RESOLUTION-1){1'b1}}};
	localparam logic [RESOLUTION-1:0] ACC_MIN = {1'b1, {(RESOLUTION-1){1'b0}}};

	logic signed [SAMPLE_WIDTH-1:0] tap_a [TAPS]; // history of input a, index 0 newest
	logic signed [SAMPLE_WIDTH-1:0] tap_b [TAPS]; // history of input b

	// returns {hit a limit, new value}, the value clamped when the limit was passed
	function automatic logic [RESOLUTION:0] sat_add(input logic signed [RESOLUTION-1:0] acc,
			input logic signed [PROD_W-1:0] prod);
		logic signed [RESOLUTION:0] sum;
		sum = acc + prod; // one guard bit keeps the true sum
		if (sum[RESOLUTION] != sum[RESOLUTION-1]) begin
			return {1'b1, sum[RESOLUTION] ? ACC_MIN : ACC_MAX}; // sign of the true sum picks the limit
		end
		return {1'b0, sum[RESOLUTION-1:0]};
	endfunction

	for (genvar t = 0; t < TAPS; t++) begin : g_tap
		assign tap_a[t] = taps[(INPUT_A*TAPS+t)*SAMPLE_WIDTH +: SAMPLE_WIDTH];
		assign tap_b[t] = taps[(INPUT_B*TAPS+t)*SAMPLE_WIDTH +: SAMPLE_WIDTH];
	end

	for (genvar k = 0; k < CHANNELS; k++) begin : g_chan
		localparam int D  = k - (LAG_CROSS-1); // negative lags delay input a
		localparam int PA = (D < 0) ? -D : 0;
		localparam int PB = (D > 0) ? D : 0;

		logic signed [PROD_W-1:0]     prod_re;  // a times b at the channel lag
		logic signed [PROD_W-1:0]     prod_im;  // a times b one tap later
		logic [RESOLUTION:0]          next_re;
		logic [RESOLUTION:0]          next_im;
		logic signed [RESOLUTION-1:0] re_q;
		logic signed [RESOLUTION-1:0] im_q;
		logic                         ovf_q;

		assign prod_re = tap_a[PA] * tap_b[PB];
		assign prod_im = tap_a[PA] * tap_b[PB+1]; // PB+1 never passes the last tap
		assign next_re = sat_add(re_q, prod_re);
		assign next_im = sat_add(im_q, prod_im);

		always_ff @(posedge pllclk) begin
			if (!reset || ctrl.clear) begin
				re_q  <= '0;
				im_q  <= '0;
				ovf_q <= 1'b0;
			end else if (taps_valid && ctrl.enable && !ovf_q) begin
				re_q  <= next_re[RESOLUTION-1:0];
				im_q  <= next_im[RESOLUTION-1:0];
				ovf_q <= next_re[RESOLUTION] | next_im[RESOLUTION]; // either sum freezes the channel
			end
		end

		assign acc_real[k*RESOLUTION +: RESOLUTION] = re_q;
		assign acc_imag[k*RESOLUTION +: RESOLUTION] = im_q;
		assign ovf[k] = ovf_q;
	end

endmodule

// File: src/corr_axil_regs.sv
// AXI4-Lite slave with one outstanding read and one outstanding write
// only REG_CTRL is writable, all other writes complete with OKAY and are dropped
// unmapped reads return zero, accumulators read sign extended to 32 bits
`timescale 1ns/1ns

module corr_axil_regs #(
	parameter int NUM_INPUTS = 4,
	parameter int LAG_CROSS  = 3,
	parameter int RESOLUTION = 24
) (
	input  logic                                          pllclk,
	input  logic                                          reset,        // synchronous, active low
	input  corr_pkg::axil_req_t                           s_axil_req,
	output corr_pkg::axil_rsp_t                           s_axil_rsp,
	input  logic                                          taps_valid,
	output corr_pkg::corr_ctrl_t                          ctrl,
	input  logic [NUM_INPUTS*(NUM_INPUTS-1)/2*(2*LAG_CROSS-1)*RESOLUTION-1:0] acc_real_all,
	input  logic [NUM_INPUTS*(NUM_INPUTS-1)/2*(2*LAG_CROSS-1)*RESOLUTION-1:0] acc_imag_all,
	input  logic [NUM_INPUTS*(NUM_INPUTS-1)/2*(2*LAG_CROSS-1)-1:0]            ovf_all
);

	localparam int CHANNELS      = 2*LAG_CROSS - 1;
	localparam int NUM_BASELINES = NUM_INPUTS*(NUM_INPUTS-1)/2;
	localparam int NUM_ACC       = NUM_BASELINES*CHANNELS;
	localparam int AW            = corr_pkg::AXIL_ADDR_WIDTH;
	localparam int DW            = corr_pkg::AXIL_DATA_WIDTH;

	logic            aw_hold;   // address accepted, data still missing
	logic            w_hold;    // data accepted, address still missing
	logic [AW-1:0]   awaddr_q;
	logic [DW-1:0]   wdata_q;
	logic [DW/8-1:0] wstrb_q;
	logic            bvalid_q;
	logic            rvalid_q;
	logic [DW-1:0]   rdata_q;
	logic [DW-1:0]   count_q;   // strobes accumulated since reset or clear

	logic            aw_hs;
	logic            w_hs;
	logic            ar_hs;
	logic            do_write;  // both halves of a write are in hand this cycle
	logic [AW-1:0]   wr_addr;
	logic [DW-1:0]   wr_data;
	logic [DW/8-1:0] wr_strb;
	logic [DW-1:0]   rd_word;
	logic [AW-1:0]   acc_off;
	logic [AW-4:0]   acc_idx;   // accumulator index, 8 bytes per entry
	logic signed [RESOLUTION-1:0] acc_sel;
	logic signed [DW-1:0]         acc_ext;
	logic [NUM_BASELINES-1:0]     ovf_sum;

	assign s_axil_rsp.awready = !aw_hold && !bvalid_q; // back pressure while a response waits
	assign s_axil_rsp.wready  = !w_hold && !bvalid_q;
	assign s_axil_rsp.bresp   = corr_pkg::RESP_OKAY;
	assign s_axil_rsp.bvalid  = bvalid_q;
	assign s_axil_rsp.arready = !rvalid_q;
	assign s_axil_rsp.rdata   = rdata_q;
	assign s_axil_rsp.rresp   = corr_pkg::RESP_OKAY;
	assign s_axil_rsp.rvalid  = rvalid_q;

	assign aw_hs    = s_axil_req.awvalid && s_axil_rsp.awready;
	assign w_hs     = s_axil_req.wvalid && s_axil_rsp.wready;
	assign ar_hs    = s_axil_req.arvalid && s_axil_rsp.arready;
	assign do_write = (aw_hold || aw_hs) && (w_hold || w_hs);
	assign wr_addr  = aw_hold ? awaddr_q : s_axil_req.awaddr;
	assign wr_data  = w_hold ? wdata_q : s_axil_req.wdata;
	assign wr_strb  = w_hold ? wstrb_q : s_axil_req.wstrb;

	// write channel, AW and W may arrive in either order
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			aw_hold  <= 1'b0;
			w_hold   <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			aw_hold  <= (aw_hold || aw_hs) && !do_write;
			w_hold   <= (w_hold || w_hs) && !do_write;
			bvalid_q <= do_write || (bvalid_q && !s_axil_req.bready); // held until bready
		end
		if (aw_hs) awaddr_q <= s_axil_req.awaddr;
		if (w_hs) begin
			wdata_q <= s_axil_req.wdata;
			wstrb_q <= s_axil_req.wstrb;
		end
	end

	// control register, clear is a single cycle pulse
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			ctrl <= '0;
		end else begin
			ctrl.clear <= 1'b0;
			if (do_write && wr_addr == corr_pkg::REG_CTRL && wr_strb[0]) begin
				ctrl.enable <= wr_data[0];
				ctrl.clear  <= wr_data[1];
			end
		end
	end

	// counts exactly the strobes the correlators accumulate
	always_ff @(posedge pllclk) begin
		if (!reset || ctrl.clear) begin
			count_q <= '0;
		end else if (taps_valid && ctrl.enable) begin
			count_q <= count_q + 1'b1;
		end
	end

	// overflow summary, one bit per baseline
	always_comb begin
		for (int m = 0; m < NUM_BASELINES; m++) begin
			ovf_sum[m] = |ovf_all[m*CHANNELS +: CHANNELS];
		end
	end

	assign acc_off = s_axil_req.araddr - corr_pkg::ACC_BASE;
	assign acc_idx = acc_off[AW-1:3];
	assign acc_sel = acc_off[2] ? acc_imag_all[acc_idx*RESOLUTION +: RESOLUTION]
		: acc_real_all[acc_idx*RESOLUTION +: RESOLUTION]; // bit 2 picks the imaginary word
	assign acc_ext = acc_sel; // signed to signed assignment extends the sign

	// read decode, word aligned, low two address bits ignored
	always_comb begin
		rd_word = '0;
		if (s_axil_req.araddr >= corr_pkg::ACC_BASE) begin
			if (acc_idx < NUM_ACC) rd_word = acc_ext;
		end else begin
			case ({s_axil_req.araddr[AW-1:2], 2'b00})
				corr_pkg::REG_CTRL:  rd_word = DW'(ctrl);
				corr_pkg::REG_COUNT: rd_word = count_q;
				corr_pkg::REG_OVF:   rd_word = DW'(ovf_sum);
				default:             rd_word = '0;
			endcase
		end
	end

	// read channel, data registered when AR is accepted and held until rready
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			rvalid_q <= 1'b0;
		end else begin
			rvalid_q <= ar_hs || (rvalid_q && !s_axil_req.rready);
		end
		if (ar_hs) rdata_q <= rd_word;
	end

endmodule

// File: src/corr_pkg.sv
// shared bus, control and register map definitions for the correlator
// the register space is 4 KiB, so NUM_BASELINES*CHANNELS must stay below 480
// all registers are 32 bits wide and accessed as whole words

package corr_pkg;

	localparam int AXIL_ADDR_WIDTH = 12; // byte address of the register space
	localparam int AXIL_DATA_WIDTH = 32; // bus word width

	// master driven half of the AXI4-Lite port
	typedef struct packed {
		logic [AXIL_ADDR_WIDTH-1:0]   awaddr;  // write address
		logic                         awvalid;
		logic [AXIL_DATA_WIDTH-1:0]   wdata;   // write data
		logic [AXIL_DATA_WIDTH/8-1:0] wstrb;   // byte lane enables
		logic                         wvalid;
		logic                         bready;
		logic [AXIL_ADDR_WIDTH-1:0]   araddr;  // read address
		logic                         arvalid;
		logic                         rready;
	} axil_req_t;

	// slave driven half of the AXI4-Lite port
	typedef struct packed {
		logic                       awready;
		logic                       wready;
		logic [1:0]                 bresp;   // always OKAY here
		logic                       bvalid;
		logic                       arready;
		logic [AXIL_DATA_WIDTH-1:0] rdata;   // read data
		logic [1:0]                 rresp;   // always OKAY here
		logic                       rvalid;
	} axil_rsp_t;

	// control word shared by every baseline correlator
	typedef struct packed {
		logic clear;  // one cycle pulse, zeros accumulators and flags
		logic enable; // accumulate while high
	} corr_ctrl_t;

	// register offsets in bytes
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_CTRL  = 12'h000; // bit 0 enable, bit 1 clear
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_COUNT = 12'h004; // accumulated sample count
	localparam logic [AXIL_ADDR_WIDTH-1:0] REG_OVF   = 12'h008; // one bit per baseline
	localparam logic [AXIL_ADDR_WIDTH-1:0] ACC_BASE  = 12'h100; // real at +8n, imag at +8n+4

	localparam logic [1:0] RESP_OKAY = 2'b00; // the only response this slave gives

endpackage

// File: src/intensity_correlator.sv
// top of the correlator, one baseline per input pair a < b
// baselines are numbered (0,1), (0,2) .. (0,N-1), (1,2) .. as in the register map
// RESOLUTION is limited to 32 so accumulators fit one bus word
`timescale 1ns/1ns

module intensity_correlator #(
	parameter int NUM_INPUTS   = 4,
	parameter int LAG_CROSS    = 3,
	parameter int SAMPLE_WIDTH = 4,  // two's complement samples
	parameter int RESOLUTION   = 24  // accumulator width
) (
	input  logic                               pllclk,
	input  logic                               reset,         // synchronous, active low
	input  logic [NUM_INPUTS*SAMPLE_WIDTH-1:0] adc_data,      // input i at slice i
	input  logic                               sample_strobe,
	input  corr_pkg::axil_req_t                s_axil_req,
	output corr_pkg::axil_rsp_t                s_axil_rsp
);

	localparam int CHANNELS      = 2*LAG_CROSS - 1;
	localparam int TAPS          = LAG_CROSS + 1;
	localparam int NUM_BASELINES = NUM_INPUTS*(NUM_INPUTS-1)/2;

	logic [NUM_INPUTS*TAPS*SAMPLE_WIDTH-1:0]       taps;
	logic                                          taps_valid;
	corr_pkg::corr_ctrl_t                          ctrl;
	logic [NUM_BASELINES*CHANNELS*RESOLUTION-1:0]  acc_real_all; // baseline major, channel minor
	logic [NUM_BASELINES*CHANNELS*RESOLUTION-1:0]  acc_imag_all;
	logic [NUM_BASELINES*CHANNELS-1:0]             ovf_all;

	sample_delay_bank #(
		.NUM_INPUTS  (NUM_INPUTS),
		.LAG_CROSS   (LAG_CROSS),
		.SAMPLE_WIDTH(SAMPLE_WIDTH)
	) u_delay_bank (
		.pllclk       (pllclk),
		.reset        (reset),
		.adc_data     (adc_data),
		.sample_strobe(sample_strobe),
		.taps         (taps),
		.taps_valid   (taps_valid)
	);

	for (genvar a = 0; a < NUM_INPUTS; a++) begin : g_in_a
		for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_in_b
			localparam int BL = a*NUM_INPUTS - a*(a+1)/2 + (b - a - 1); // pair to baseline index

			baseline_correlator #(
				.INPUT_A     (a),
				.INPUT_B     (b),
				.NUM_INPUTS  (NUM_INPUTS),
				.LAG_CROSS   (LAG_CROSS),
				.SAMPLE_WIDTH(SAMPLE_WIDTH),
				.RESOLUTION  (RESOLUTION)
			) u_baseline (
				.pllclk    (pllclk),
				.reset     (reset),
				.taps      (taps),
				.taps_valid(taps_valid),
				.ctrl      (ctrl),
				.acc_real  (acc_real_all[BL*CHANNELS*RESOLUTION +: CHANNELS*RESOLUTION]),
				.acc_imag  (acc_imag_all[BL*CHANNELS*RESOLUTION +: CHANNELS*RESOLUTION]),
				.ovf       (ovf_all[BL*CHANNELS +: CHANNELS])
			);
		end
	end

	corr_axil_regs #(
		.NUM_INPUTS(NUM_INPUTS),
		.LAG_CROSS (LAG_CROSS),
		.RESOLUTION(RESOLUTION)
	) u_regs (
		.pllclk      (pllclk),
		.reset       (reset),
		.s_axil_req  (s_axil_req),
		.s_axil_rsp  (s_axil_rsp),
		.taps_valid  (taps_valid),
		.ctrl        (ctrl),
		.acc_real_all(acc_real_all),
		.acc_imag_all(acc_imag_all),
		.ovf_all     (ovf_all)
	);

endmodule

// File: src/sample_delay_bank.sv
// keeps the last LAG_CROSS+1 samples of every input, tap 0 being the newest
// the history only moves on sample_strobe, so taps are stable between strobes
// input i tap t sits at taps[(i*TAPS+t)*SAMPLE_WIDTH +: SAMPLE_WIDTH]
`timescale 1ns/1ns

module sample_delay_bank #(
	parameter int NUM_INPUTS   = 4,
	parameter int LAG_CROSS    = 3,
	parameter int SAMPLE_WIDTH = 4
) (
	input  logic                                          pllclk,
	input  logic                                          reset,         // synchronous, active low
	input  logic [NUM_INPUTS*SAMPLE_WIDTH-1:0]            adc_data,      // input i at slice i
	input  logic                                          sample_strobe,
	output logic [NUM_INPUTS*(LAG_CROSS+1)*SAMPLE_WIDTH-1:0] taps,
	output logic                                          taps_valid
);

	localparam int TAPS = LAG_CROSS + 1; // one extra tap feeds the quadrature products

	// taps_valid marks the cycle in which the freshly shifted history is on the bus
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			taps_valid <= 1'b0;
		end else begin
			taps_valid <= sample_strobe; // one pulse per strobe, even back to back
		end
	end

	// history shift, cleared on reset so that the first lags multiply by zero
	always_ff @(posedge pllclk) begin
		if (!reset) begin
			taps <= '0;
		end else if (sample_strobe) begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				taps[(i*TAPS)*SAMPLE_WIDTH +: SAMPLE_WIDTH] <=
					adc_data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]; // newest sample into tap 0
				for (int t = 1; t < TAPS; t++) begin
					taps[(i*TAPS+t)*SAMPLE_WIDTH +: SAMPLE_WIDTH] <=
						taps[(i*TAPS+t-1)*SAMPLE_WIDTH +: SAMPLE_WIDTH]; // older ones move up
				end
			end
		end
	end

endmodule
